// File: common/memoryPkg.sv
package memoryPkg;

  // One request from a requester toward the next level.
  typedef struct packed {
    logic        readEnable;
    logic        writeEnable;
    logic [31:0] address;  // Word address.
    logic [31:0] data;
  } memRequest_t;

  // Answer to the request currently presented.
  typedef struct packed {
    logic [31:0] data;
    logic        ready;  // Level, valid for the held request only.
  } memResponse_t;

  // Cache controller states.
  typedef enum logic [1:0] {
    Idle,
    Lookup,
    Fill,
    WriteThrough
  } cacheState_t;

  // Peripheral space.
  localparam int PeripheralBit = 31;  // Set selects peripherals.
  localparam int LedWidth = 6;

  localparam logic [31:0] LedAddress = 32'h8000_0000;
  localparam logic [31:0] ButtonAddress = 32'h8000_0004;

endpackage

// File: cache/CacheL1.sv
`timescale 1ns/1ps

module CacheL1 #(
  parameter int CacheLines = 16
) (
  input  logic                     clk,
  input  logic                     reset,
  input  memoryPkg::memRequest_t   request,
  output memoryPkg::memResponse_t  response,
  output memoryPkg::memRequest_t   memoryRequest,
  input  memoryPkg::memResponse_t  memoryResponse
);

  localparam int IndexBits = $clog2(CacheLines);
  localparam int TagBits = 32 - IndexBits;

  typedef struct packed {
    logic [TagBits-1:0] tag;
    logic [31:0]        data;
  } cacheLine_t;

  memoryPkg::cacheState_t state;
  memoryPkg::cacheState_t nextState;

  logic [CacheLines-1:0] lineValid;
  cacheLine_t            lines [CacheLines];

  logic [IndexBits-1:0] index;
  logic [TagBits-1:0]   requestTag;
  logic                 hit;
  logic                 lineWrite;
  logic [31:0]          lineWriteData;

  assign index = request.address[IndexBits-1:0];
  assign requestTag = request.address[31:IndexBits];
  assign hit = lineValid[index] && (lines[index].tag == requestTag);

  // Fill and store both leave the line holding the requested word.
  assign lineWrite = memoryResponse.ready &&
                     ((state == memoryPkg::Fill) || (state == memoryPkg::WriteThrough));
  assign lineWriteData = (state == memoryPkg::Fill) ? memoryResponse.data : request.data;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= memoryPkg::Idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      memoryPkg::Idle: begin
        if (request.writeEnable) begin
          nextState = memoryPkg::WriteThrough;
        end else if (request.readEnable) begin
          nextState = memoryPkg::Lookup;
        end
      end
      memoryPkg::Lookup: begin
        if (!request.readEnable || hit) begin
          nextState = memoryPkg::Idle;
        end else begin
          nextState = memoryPkg::Fill;  // Miss.
        end
      end
      memoryPkg::Fill: begin
        if (memoryResponse.ready) begin
          nextState = memoryPkg::Lookup;  // Hits on the new line.
        end
      end
      memoryPkg::WriteThrough: begin
        if (memoryResponse.ready) begin
          nextState = memoryPkg::Idle;
        end
      end
      default: nextState = memoryPkg::Idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lineValid <= '0;
    end else if (lineWrite) begin
      lineValid[index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (lineWrite) begin
      lines[index] <= '{tag: requestTag, data: lineWriteData};
    end
  end

  always_comb begin
    memoryRequest.readEnable = (state == memoryPkg::Fill);
    memoryRequest.writeEnable = (state == memoryPkg::WriteThrough);
    memoryRequest.address = request.address;
    memoryRequest.data = request.data;
  end

  always_comb begin
    response.data = lines[index].data;
    response.ready = ((state == memoryPkg::Lookup) && hit) ||
                     ((state == memoryPkg::WriteThrough) && memoryResponse.ready);
  end

endmodule

// File: design/ButtonSync.sv
`timescale 1ns/1ps

module ButtonSync #(
  parameter int DebounceCycles = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic button,
  output logic buttonLevel
);

  localparam int CountBits = $clog2(DebounceCycles + 1);

  logic [1:0]           syncStage;
  logic [CountBits-1:0] stableCount;

  always_ff @(posedge clk) begin
    if (reset) begin
      syncStage <= '0;
      stableCount <= '0;
      buttonLevel <= 1'b0;
    end else begin
      syncStage <= {syncStage[0], button};
      if (syncStage[1] == buttonLevel) begin
        stableCount <= '0;  // Bounce restarts the count.
      end else if (stableCount == CountBits'(DebounceCycles - 1)) begin
        stableCount <= '0;
        buttonLevel <= syncStage[1];
      end else begin
        stableCount <= stableCount + 1'b1;
      end
    end
  end

endmodule

// File: design/MemoryHandler.sv
`timescale 1ns/1ps

module MemoryHandler #(
  parameter int MemoryWords = 1024
) (
  input  logic                              clk,
  input  logic                              reset,
  input  memoryPkg::memRequest_t            instructionRequest,
  output memoryPkg::memResponse_t           instructionResponse,
  input  memoryPkg::memRequest_t            dataRequest,
  output memoryPkg::memResponse_t           dataResponse,
  input  logic                              buttonLevel,
  output logic [memoryPkg::LedWidth-1:0]    led
);

  localparam int AddressBits = $clog2(MemoryWords);

  logic [31:0] memory [MemoryWords];

  logic [AddressBits-1:0] instructionIndex;
  logic [AddressBits-1:0] dataIndex;
  logic [31:0]            instructionReadData;
  logic [31:0]            dataReadData;
  logic                   instructionReadValid;
  logic                   dataReadValid;

  logic        dataIsPeripheral;
  logic        memoryRead;
  logic        memoryWrite;
  logic [31:0] peripheralData;

  assign instructionIndex = instructionRequest.address[AddressBits-1:0];
  assign dataIndex = dataRequest.address[AddressBits-1:0];

  assign dataIsPeripheral = dataRequest.address[memoryPkg::PeripheralBit];
  assign memoryRead = dataRequest.readEnable && !dataIsPeripheral;
  assign memoryWrite = dataRequest.writeEnable && !dataIsPeripheral;

  // Write and read on the data port, read only on the instruction port.
  always_ff @(posedge clk) begin
    if (memoryWrite) begin
      memory[dataIndex] <= dataRequest.data;
    end
    dataReadData <= memory[dataIndex];
  end

  always_ff @(posedge clk) begin
    instructionReadData <= memory[instructionIndex];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      instructionReadValid <= 1'b0;
      dataReadValid <= 1'b0;
    end else begin
      instructionReadValid <= instructionRequest.readEnable;
      dataReadValid <= memoryRead;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      led <= '0;
    end else if (dataRequest.writeEnable && (dataRequest.address == memoryPkg::LedAddress)) begin
      led <= dataRequest.data[memoryPkg::LedWidth-1:0];
    end
  end

  always_comb begin
    case (dataRequest.address)
      memoryPkg::LedAddress:    peripheralData = {{(32 - memoryPkg::LedWidth){1'b0}}, led};
      memoryPkg::ButtonAddress: peripheralData = {31'b0, buttonLevel};
      default:                  peripheralData = '0;  // Unmapped.
    endcase
  end

  always_comb begin
    instructionResponse.data = instructionReadData;
    instructionResponse.ready = instructionReadValid;
  end

  always_comb begin
    if (dataIsPeripheral) begin
      dataResponse.data = peripheralData;
      dataResponse.ready = dataRequest.readEnable || dataRequest.writeEnable;
    end else begin
      dataResponse.data = dataReadData;
      dataResponse.ready = memoryWrite || dataReadValid;  // Writes finish at once.
    end
  end

endmodule

// File: design/MMU.sv
`timescale 1ns/1ps

module MMU #(
  parameter int CacheLines = 16,
  parameter int MemoryWords = 1024
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           dataMemoryReadEnable,
  input  logic                           dataMemoryWriteEnable,
  input  logic [31:0]                    dataMemoryAddress,
  input  logic [31:0]                    dataMemoryDataIn,
  output logic [31:0]                    dataMemoryDataOut,
  output logic                           dataMemorySuccess,
  input  logic [31:0]                    instructionMemoryAddress,
  output logic [31:0]                    instructionMemoryDataOut,
  output logic                           instructionMemorySuccess,
  input  logic                           buttonLevel,
  output logic [memoryPkg::LedWidth-1:0] led
);

  logic dataIsPeripheral;
  logic instructionIsPeripheral;

  memoryPkg::memRequest_t  dataCoreRequest;
  memoryPkg::memRequest_t  dataCacheRequest;
  memoryPkg::memResponse_t dataCacheResponse;
  memoryPkg::memRequest_t  dataCacheToMemory;
  memoryPkg::memRequest_t  dataHandlerRequest;
  memoryPkg::memResponse_t dataHandlerResponse;

  memoryPkg::memRequest_t  instructionCacheRequest;
  memoryPkg::memResponse_t instructionCacheResponse;
  memoryPkg::memRequest_t  instructionCacheToMemory;
  memoryPkg::memResponse_t instructionHandlerResponse;

  // Each port decodes its own address.
  assign dataIsPeripheral = dataMemoryAddress[memoryPkg::PeripheralBit];
  assign instructionIsPeripheral = instructionMemoryAddress[memoryPkg::PeripheralBit];

  assign dataCoreRequest = '{
    readEnable:  dataMemoryReadEnable,
    writeEnable: dataMemoryWriteEnable,
    address:     dataMemoryAddress,
    data:        dataMemoryDataIn
  };

  always_comb begin
    dataCacheRequest = dataCoreRequest;
    dataCacheRequest.readEnable = dataMemoryReadEnable && !dataIsPeripheral;
    dataCacheRequest.writeEnable = dataMemoryWriteEnable && !dataIsPeripheral;
  end

  always_comb begin
    instructionCacheRequest.readEnable = !instructionIsPeripheral;  // Fetch always reads.
    instructionCacheRequest.writeEnable = 1'b0;
    instructionCacheRequest.address = instructionMemoryAddress;
    instructionCacheRequest.data = '0;
  end

  // Peripheral accesses skip the data cache.
  assign dataHandlerRequest = dataIsPeripheral ? dataCoreRequest : dataCacheToMemory;

  CacheL1 #(
    .CacheLines(CacheLines)
  ) instructionCache (
    .clk(clk),
    .reset(reset),
    .request(instructionCacheRequest),
    .response(instructionCacheResponse),
    .memoryRequest(instructionCacheToMemory),
    .memoryResponse(instructionHandlerResponse)
  );

  CacheL1 #(
    .CacheLines(CacheLines)
  ) dataCache (
    .clk(clk),
    .reset(reset),
    .request(dataCacheRequest),
    .response(dataCacheResponse),
    .memoryRequest(dataCacheToMemory),
    .memoryResponse(dataHandlerResponse)
  );

  MemoryHandler #(
    .MemoryWords(MemoryWords)
  ) memoryHandler (
    .clk(clk),
    .reset(reset),
    .instructionRequest(instructionCacheToMemory),
    .instructionResponse(instructionHandlerResponse),
    .dataRequest(dataHandlerRequest),
    .dataResponse(dataHandlerResponse),
    .buttonLevel(buttonLevel),
    .led(led)
  );

  assign dataMemoryDataOut = dataIsPeripheral ? dataHandlerResponse.data : dataCacheResponse.data;
  assign dataMemorySuccess = dataIsPeripheral ? dataHandlerResponse.ready : dataCacheResponse.ready;

  // No fetches from peripheral space.
  assign instructionMemoryDataOut = instructionIsPeripheral ? '0 : instructionCacheResponse.data;
  assign instructionMemorySuccess = instructionIsPeripheral ? 1'b1 : instructionCacheResponse.ready;

endmodule

// File: design/MemorySystem.sv
`timescale 1ns/1ps

module MemorySystem #(
  parameter int CacheLines = 16,
  parameter int MemoryWords = 1024,
  parameter int DebounceCycles = 4
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           dataMemoryReadEnable,
  input  logic                           dataMemoryWriteEnable,
  input  logic [31:0]                    dataMemoryAddress,
  input  logic [31:0]                    dataMemoryDataIn,
  output logic [31:0]                    dataMemoryDataOut,
  output logic                           dataMemorySuccess,
  input  logic [31:0]                    instructionMemoryAddress,
  output logic [31:0]                    instructionMemoryDataOut,
  output logic                           instructionMemorySuccess,
  input  logic                           button,  // Raw, asynchronous.
  output logic [memoryPkg::LedWidth-1:0] led
);

  logic buttonLevel;

  ButtonSync #(
    .DebounceCycles(DebounceCycles)
  ) buttonSync (
    .clk(clk),
    .reset(reset),
    .button(button),
    .buttonLevel(buttonLevel)
  );

  MMU #(
    .CacheLines(CacheLines),
    .MemoryWords(MemoryWords)
  ) mmu (
    .clk(clk),
    .reset(reset),
    .dataMemoryReadEnable(dataMemoryReadEnable),
    .dataMemoryWriteEnable(dataMemoryWriteEnable),
    .dataMemoryAddress(dataMemoryAddress),
    .dataMemoryDataIn(dataMemoryDataIn),
    .dataMemoryDataOut(dataMemoryDataOut),
    .dataMemorySuccess(dataMemorySuccess),
    .instructionMemoryAddress(instructionMemoryAddress),
    .instructionMemoryDataOut(instructionMemoryDataOut),
    .instructionMemorySuccess(instructionMemorySuccess),
    .buttonLevel(buttonLevel),
    .led(led)
  );

endmodule

// File: testbench/ClockGen.sv
`timescale 1ns/1ps

module ClockGen #(
  parameter realtime HalfPeriod = 2.0ns,
  parameter int ResetCycles = 2
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(HalfPeriod) clk = ~clk;
  end

  // Released on a falling edge, away from the sampling edge.
  initial begin
    reset = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// File: testbench/memorySystemTb.sv
`timescale 1ns/1ps

module memorySystemTb;

  localparam int Timeout = 100;
  localparam logic [31:0] Seed = 32'hd9807a3a;

  logic                           clk;
  logic                           reset;
  logic                           dataMemoryReadEnable;
  logic                           dataMemoryWriteEnable;
  logic [31:0]                    dataMemoryAddress;
  logic [31:0]                    dataMemoryDataIn;
  logic [31:0]                    dataMemoryDataOut;
  logic                           dataMemorySuccess;
  logic [31:0]                    instructionMemoryAddress;
  logic [31:0]                    instructionMemoryDataOut;
  logic                           instructionMemorySuccess;
  logic                           button;
  logic [memoryPkg::LedWidth-1:0] led;

  logic [31:0]                    referenceMemory [logic [31:0]];
  logic [31:0]                    expectedData;
  logic [31:0]                    expectedFetch;
  logic [memoryPkg::LedWidth-1:0] expectedLed;
  logic                           checkRead;
  logic                           checkFetch;
  logic                           firstCycle;
  int                             errorCount;
  int                             timeoutCount;
  int                             accessCount;

  ClockGen clockGen (
    .clk(clk),
    .reset(reset)
  );

  MemorySystem #(
    .CacheLines(16),
    .MemoryWords(1024),
    .DebounceCycles(4)
  ) uut (
    .clk(clk),
    .reset(reset),
    .dataMemoryReadEnable(dataMemoryReadEnable),
    .dataMemoryWriteEnable(dataMemoryWriteEnable),
    .dataMemoryAddress(dataMemoryAddress),
    .dataMemoryDataIn(dataMemoryDataIn),
    .dataMemoryDataOut(dataMemoryDataOut),
    .dataMemorySuccess(dataMemorySuccess),
    .instructionMemoryAddress(instructionMemoryAddress),
    .instructionMemoryDataOut(instructionMemoryDataOut),
    .instructionMemorySuccess(instructionMemorySuccess),
    .button(button),
    .led(led)
  );

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
    errorCount++;
    $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
  endtask

  assert property (@(posedge clk) disable iff (reset)
      (dataMemorySuccess && dataMemoryReadEnable && checkRead) |->
      (dataMemoryDataOut == expectedData))
    else reportMismatch("dataMemoryDataOut", $sampled(dataMemoryDataOut),
                        $sampled(expectedData));

  assert property (@(posedge clk) disable iff (reset)
      (instructionMemorySuccess && checkFetch) |-> (instructionMemoryDataOut == expectedFetch))
    else reportMismatch("instructionMemoryDataOut", $sampled(instructionMemoryDataOut),
                        $sampled(expectedFetch));

  assert property (@(posedge clk) disable iff (reset) led == expectedLed)
    else reportMismatch("led", 32'($sampled(led)), 32'($sampled(expectedLed)));

  // Peripheral accesses finish in the cycle they appear.
  assert property (@(posedge clk) disable iff (reset)
      (dataMemoryAddress[memoryPkg::PeripheralBit] &&
       (dataMemoryReadEnable || dataMemoryWriteEnable)) |-> dataMemorySuccess)
    else reportMismatch("dataMemorySuccess", 32'd0, 32'd1);

  assert property (@(posedge clk) disable iff (reset)
      (dataMemorySuccess && dataMemoryReadEnable &&
       (dataMemoryAddress == memoryPkg::ButtonAddress)) |-> (dataMemoryDataOut[31:1] == '0))
    else reportMismatch("dataMemoryDataOut[31:1]", 32'($sampled(dataMemoryDataOut[31:1])),
                        32'd0);

  assert property (@(posedge clk) disable iff (reset) firstCycle |-> !dataMemorySuccess)
    else reportMismatch("dataMemorySuccess", 32'd1, 32'd0);

  assert property (@(posedge clk) disable iff (reset) firstCycle |-> !instructionMemorySuccess)
    else reportMismatch("instructionMemorySuccess", 32'd1, 32'd0);

  task automatic waitForSuccess(input logic needData, input logic needFetch, input string what);
    logic dataDone;
    logic fetchDone;
    int   cycles;
    dataDone = !needData;
    fetchDone = !needFetch;
    cycles = 0;
    while (!(dataDone && fetchDone) && (cycles < Timeout)) begin
      @(posedge clk);
      cycles++;
      if (dataMemorySuccess) dataDone = 1'b1;
      if (instructionMemorySuccess) fetchDone = 1'b1;
    end
    if (!(dataDone && fetchDone)) begin
      timeoutCount++;
      $display("timeout: %s did not complete within %0d cycles", what, Timeout);
    end
  endtask

  task automatic dataWrite(input logic [31:0] address, input logic [31:0] value);
    @(negedge clk);
    checkRead = 1'b0;
    dataMemoryWriteEnable = 1'b1;
    dataMemoryAddress = address;
    dataMemoryDataIn = value;
    waitForSuccess(1'b1, 1'b0, "data write");
    @(negedge clk);
    dataMemoryWriteEnable = 1'b0;
    if (address == memoryPkg::LedAddress) begin
      expectedLed = value[memoryPkg::LedWidth-1:0];  // Written on the completing edge.
    end else if (!address[memoryPkg::PeripheralBit]) begin
      referenceMemory[address] = value;
    end
    accessCount++;
  endtask

  task automatic dataRead(input logic [31:0] address);
    @(negedge clk);
    if (address == memoryPkg::LedAddress) begin
      expectedData = 32'(expectedLed);
    end else begin
      expectedData = referenceMemory[address];
    end
    checkRead = 1'b1;
    dataMemoryReadEnable = 1'b1;
    dataMemoryAddress = address;
    waitForSuccess(1'b1, 1'b0, "data read");
    @(negedge clk);
    dataMemoryReadEnable = 1'b0;
    accessCount++;
  endtask

  // Idle fetches point at peripheral space, which reads zero.
  task automatic parkFetch();
    instructionMemoryAddress = memoryPkg::LedAddress;
    expectedFetch = '0;
    checkFetch = 1'b1;
  endtask

  task automatic fetchWord(input logic [31:0] address);
    @(negedge clk);
    expectedFetch = referenceMemory[address];
    instructionMemoryAddress = address;
    waitForSuccess(1'b0, 1'b1, "instruction fetch");
    @(negedge clk);
    parkFetch();
    accessCount++;
  endtask

  task automatic accessBoth(input logic [31:0] fetchAddress, input logic [31:0] dataAddress);
    @(negedge clk);
    expectedFetch = referenceMemory[fetchAddress];
    instructionMemoryAddress = fetchAddress;
    expectedData = referenceMemory[dataAddress];
    checkRead = 1'b1;
    dataMemoryReadEnable = 1'b1;
    dataMemoryAddress = dataAddress;
    waitForSuccess(1'b1, 1'b1, "concurrent fetch and load");
    @(negedge clk);
    dataMemoryReadEnable = 1'b0;
    parkFetch();
    accessCount += 2;
  endtask

  task automatic pollButton(input logic level);
    int   cycles;
    logic seen;
    cycles = 0;
    seen = 1'b0;
    @(negedge clk);
    button = level;
    checkRead = 1'b0;
    dataMemoryReadEnable = 1'b1;
    dataMemoryAddress = memoryPkg::ButtonAddress;
    while (!seen && (cycles < Timeout)) begin
      @(posedge clk);
      cycles++;
      seen = dataMemorySuccess && (dataMemoryDataOut[0] == level);
    end
    if (!seen) begin
      timeoutCount++;
      $display("timeout: button read did not return %0d within %0d cycles", level, Timeout);
    end
    @(negedge clk);
    dataMemoryReadEnable = 1'b0;
    accessCount++;
  endtask

  initial begin
    logic [31:0] address;
    logic [31:0] value;
    logic [31:0] conflictA;
    logic [31:0] conflictB;
    int          cycles;
    void'($urandom(Seed));
    errorCount = 0;
    timeoutCount = 0;
    accessCount = 0;
    address = $urandom_range(0, 255);
    value = $urandom;
    button = 1'b0;
    dataMemoryReadEnable = 1'b0;
    dataMemoryWriteEnable = 1'b1;  // Held through reset into the first cycle.
    dataMemoryAddress = address;
    dataMemoryDataIn = value;
    instructionMemoryAddress = 32'd900;
    expectedData = '0;
    expectedFetch = '0;
    expectedLed = '0;
    checkRead = 1'b0;
    checkFetch = 1'b0;  // Uninitialized memory.
    firstCycle = 1'b1;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while ((reset !== 1'b0) && (cycles < Timeout));
    if (reset !== 1'b0) begin
      timeoutCount++;
      $display("timeout: reset was not released within %0d cycles", Timeout);
    end
    @(negedge clk);
    firstCycle = 1'b0;
    waitForSuccess(1'b1, 1'b1, "first requests after reset");
    @(negedge clk);
    dataMemoryWriteEnable = 1'b0;
    referenceMemory[address] = value;
    parkFetch();
    accessCount += 2;

    address = $urandom_range(0, 255);
    dataWrite(address, $urandom);
    dataRead(address);
    dataRead(address);  // Hit.

    // Same index, different tag.
    conflictA = 32'd64 + $urandom_range(0, 15);
    conflictB = conflictA + 32'd256;
    for (int i = 0; i < 3; i++) begin
      dataWrite(conflictA, $urandom);
      dataWrite(conflictB, $urandom);
      dataRead(conflictA);
      dataRead(conflictB);
    end

    for (int i = 0; i < 4; i++) dataWrite(32'd600 + i, $urandom);
    for (int i = 0; i < 4; i++) fetchWord(32'd600 + i);
    for (int i = 0; i < 4; i++) dataWrite(32'd620 + i, $urandom);
    for (int i = 0; i < 4; i++) accessBoth(32'd620 + i, 32'd600 + i);

    value = $urandom;
    dataWrite(memoryPkg::LedAddress, value);
    dataRead(memoryPkg::LedAddress);
    dataWrite(memoryPkg::LedAddress, ~value);  // Every LED bit toggles.
    dataRead(memoryPkg::LedAddress);
    pollButton(1'b1);
    pollButton(1'b0);

    // 64 words over 16 lines.
    repeat (200) begin
      address = 32'd256 + $urandom_range(0, 63);
      if (($urandom_range(0, 1) == 1) && referenceMemory.exists(address)) begin
        dataRead(address);
      end else begin
        dataWrite(address, $urandom);
      end
    end

    repeat (2) @(negedge clk);
    $display("accesses %0d, errors %0d, timeouts %0d", accessCount, errorCount, timeoutCount);
    if ((errorCount == 0) && (timeoutCount == 0)) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: MemorySystem.f
common/memoryPkg.sv
cache/CacheL1.sv
design/ButtonSync.sv
design/MemoryHandler.sv
design/MMU.sv
design/MemorySystem.sv
testbench/ClockGen.sv
testbench/memorySystemTb.sv

// File: Bender.yml
package:
  name: memory_system

sources:
  - common/memoryPkg.sv
  - cache/CacheL1.sv
  - design/ButtonSync.sv
  - design/MemoryHandler.sv
  - design/MMU.sv
  - design/MemorySystem.sv
  - target: test
    files:
      - testbench/ClockGen.sv
      - testbench/memorySystemTb.sv
